// File: compile.f
src/conv_pkg.sv
src/conv_ctrl_pkg.sv
src/conv_ram.sv
src/conv_control.sv
src/conv_addr_gen.sv
src/conv_datapath.sv
src/conv_top.sv
verification/conv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the conv testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module conv_tb -o conv_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output="$(./obj_dir/conv_sim)"; then
    echo "$output"
    echo "Simulator returned a failing status"
    exit 1
fi

echo "$output"

if grep -qx "Simulation PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: src/conv_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module conv_addr_gen (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        conv,
    input  wire logic                        counter_enable,
    input  wire logic [conv_pkg::ADDR_W-1:0] length,

    output logic [conv_pkg::ADDR_W-1:0]      rd_addr0,
    output logic [conv_pkg::ADDR_W-1:0]      rd_addr1,
    output logic [conv_pkg::ADDR_W-1:0]      rd_addr2,
    output logic [conv_pkg::ADDR_W-1:0]      wr_addr,
    output logic                             done
);

    import conv_pkg::*;

    logic [ADDR_W-1:0] pos_q;
    logic [ADDR_W-1:0] len_q;
    logic [ADDR_W-1:0] last_pos;

    //////////////////////////////////////////////////
    // Window position and run length.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pos_q <= '0;
            len_q <= '0;
        end
        else if (conv)
        begin
            pos_q <= '0;
            len_q <= length;
        end
        else if (counter_enable)
        begin
            pos_q <= pos_q + ADDR_W'(1);
        end
    end

    // A length of MEM_DEPTH wraps to zero, and the modulo
    // subtraction still lands on the last position.
    assign last_pos = len_q - ADDR_W'(2);
    assign done     = (pos_q == last_pos);

    //////////////////////////////////////////////////
    // Addresses.
    //////////////////////////////////////////////////

    assign rd_addr0 = pos_q;
    assign rd_addr1 = pos_q + ADDR_W'(1);
    assign rd_addr2 = pos_q + ADDR_W'(2);

    // Result lands at the window's first sample.
    assign wr_addr = pos_q;

endmodule

`default_nettype wire

// File: src/conv_control.sv
`timescale 1ns/1ps
`default_nettype none

module conv_control (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              conv,
    input  wire logic              done,

    output logic                   addr,
    output logic                   load,
    output conv_ctrl_pkg::tap_sel_t mux_sel,
    output logic                   acc_enable,
    output logic                   counter_enable,
    output logic                   store,
    output logic                   busy
);

    import conv_ctrl_pkg::*;

    state_t state_q;
    state_t state_d;

    //////////////////////////////////////////////////
    // State register.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Any state but IDLE belongs to a run.
    assign busy = (state_q != IDLE);

    //////////////////////////////////////////////////
    // Next state and strobes.
    //////////////////////////////////////////////////

    always_comb
    begin
        addr           = 1'b0;
        load           = 1'b0;
        mux_sel        = TAP_NONE;
        acc_enable     = 1'b0;
        store          = 1'b0;
        counter_enable = 1'b0;
        state_d        = state_q;

        case (state_q)
            IDLE:
            begin
                state_d = conv ? ADDR : IDLE;
            end
            ADDR:
            begin
                addr    = 1'b1;
                state_d = LOAD;
            end
            LOAD:
            begin
                load    = 1'b1;
                state_d = MAC0;
            end
            MAC0:
            begin
                mux_sel = TAP_0;
                state_d = MAC1;
            end
            MAC1:
            begin
                mux_sel = TAP_1;
                state_d = MAC2;
            end
            MAC2:
            begin
                mux_sel = TAP_2;
                state_d = SUM;
            end
            // Last product drains into the sum here.
            SUM:
            begin
                state_d = ACC;
            end
            ACC:
            begin
                acc_enable = 1'b1;
                state_d    = STORE;
            end
            STORE:
            begin
                store   = 1'b1;
                state_d = UPDATE_COUNTERS;
            end
            UPDATE_COUNTERS:
            begin
                counter_enable = 1'b1;
                state_d        = CHECK_DONE;
            end
            CHECK_DONE:
            begin
                state_d = done ? IDLE : ADDR;
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/conv_ctrl_pkg.sv
`default_nettype none

package conv_ctrl_pkg;

    // Sequencer states, one window per pass from ADDR to CHECK_DONE.
    typedef enum logic [3:0] {
        IDLE            = 4'd0,
        ADDR            = 4'd1,
        LOAD            = 4'd2,
        MAC0            = 4'd3,
        MAC1            = 4'd4,
        MAC2            = 4'd5,
        SUM             = 4'd6,
        ACC             = 4'd7,
        STORE           = 4'd8,
        UPDATE_COUNTERS = 4'd9,
        CHECK_DONE      = 4'd10
    } state_t;

    // Tap select, TAP_NONE feeds a zero operand.
    typedef enum logic [1:0] {
        TAP_NONE = 2'd0,
        TAP_0    = 2'd1,
        TAP_1    = 2'd2,
        TAP_2    = 2'd3
    } tap_sel_t;

endpackage

`default_nettype wire

// File: src/conv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath (
    input  wire logic                        clk,
    input  wire logic                        rst_n,

    input  wire logic                        smp_we,
    input  wire logic [conv_pkg::ADDR_W-1:0] smp_waddr,
    input  conv_pkg::sample_t                smp_wdata,

    input  wire logic [conv_pkg::ADDR_W-1:0] rd_addr0,
    input  wire logic [conv_pkg::ADDR_W-1:0] rd_addr1,
    input  wire logic [conv_pkg::ADDR_W-1:0] rd_addr2,
    input  wire logic [conv_pkg::ADDR_W-1:0] wr_addr,

    input  wire logic [conv_pkg::ADDR_W-1:0] res_raddr,
    output conv_pkg::result_t                res_rdata,

    input  wire logic                        cfg_load,
    input  conv_pkg::weight_t                w0,
    input  conv_pkg::weight_t                w1,
    input  conv_pkg::weight_t                w2,
    input  conv_pkg::weight_t                bias,

    input  wire logic                        addr,
    input  wire logic                        load,
    input  conv_ctrl_pkg::tap_sel_t          mux_sel,
    input  wire logic                        acc_enable,
    input  wire logic                        store
);

    import conv_pkg::*;
    import conv_ctrl_pkg::*;

    logic [ADDR_W-1:0] rd_addr [TAPS];
    sample_t           bank_q  [TAPS];
    sample_t           win_q   [TAPS];
    weight_t           wgt_q   [TAPS];
    weight_t           bias_q;
    sample_t           op_s;
    weight_t           op_w;
    prod_t             prod_q;
    psum_t             psum_q;
    psum_t             biased;
    psum_t             shifted;
    result_t           sat;
    result_t           result_q;

    //////////////////////////////////////////////////
    // Sample banks, one per tap.
    //////////////////////////////////////////////////

    assign rd_addr[0] = rd_addr0;
    assign rd_addr[1] = rd_addr1;
    assign rd_addr[2] = rd_addr2;

    for (genvar t = 0; t < TAPS; t++)
    begin : g_bank
        conv_ram #(.word_t(sample_t), .DEPTH(MEM_DEPTH)) u_bank (
            .clk   (clk),
            .we    (smp_we),
            .waddr (smp_waddr),
            .wdata (smp_wdata),
            .re    (addr),
            .raddr (rd_addr[t]),
            .rdata (bank_q[t])
        );
    end

    //////////////////////////////////////////////////
    // Configuration and window registers.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < TAPS; i++)
            begin
                wgt_q[i] <= '0;
                win_q[i] <= '0;
            end
            bias_q <= '0;
        end
        else
        begin
            if (cfg_load)
            begin
                wgt_q[0] <= w0;
                wgt_q[1] <= w1;
                wgt_q[2] <= w2;
                bias_q   <= bias;
            end
            if (load)
            begin
                win_q <= bank_q;
            end
        end
    end

    // Tap mux.
    always_comb
    begin
        op_s = '0;
        op_w = '0;
        case (mux_sel)
            TAP_0:
            begin
                op_s = win_q[0];
                op_w = wgt_q[0];
            end
            TAP_1:
            begin
                op_s = win_q[1];
                op_w = wgt_q[1];
            end
            TAP_2:
            begin
                op_s = win_q[2];
                op_w = wgt_q[2];
            end
            default:
            begin
                op_s = '0;
                op_w = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Multiply-accumulate, one product stage deep.
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prod_q <= '0;
            psum_q <= '0;
        end
        else
        begin
            prod_q <= op_s * op_w;
            if (load)
            begin
                psum_q <= '0;
            end
            else
            begin
                psum_q <= psum_q + psum_t'(prod_q);
            end
        end
    end

    // Bias, shift, saturate.
    assign biased  = psum_q + psum_t'(bias_q);
    assign shifted = biased >>> OUT_SHIFT;

    always_comb
    begin
        if (shifted > RES_MAX)
        begin
            sat = result_t'(RES_MAX);
        end
        else if (shifted < RES_MIN)
        begin
            sat = result_t'(RES_MIN);
        end
        else
        begin
            sat = result_t'(shifted);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result_q <= '0;
        end
        else if (acc_enable)
        begin
            result_q <= sat;
        end
    end

    //////////////////////////////////////////////////
    // Result memory.
    //////////////////////////////////////////////////

    conv_ram #(.word_t(result_t), .DEPTH(MEM_DEPTH)) u_result (
        .clk   (clk),
        .we    (store),
        .waddr (wr_addr),
        .wdata (result_q),
        .re    (1'b1),
        .raddr (res_raddr),
        .rdata (res_rdata)
    );

endmodule

`default_nettype wire

// File: src/conv_pkg.sv
`default_nettype none

package conv_pkg;

    //////////////////////////////////////////////////
    // Memory geometry.
    //////////////////////////////////////////////////

    localparam int MEM_DEPTH = 64;
    localparam int ADDR_W    = $clog2(MEM_DEPTH);

    // Window width, fixed by the three MAC states.
    localparam int TAPS = 3;

    // Arithmetic right shift after the bias add.
    localparam int OUT_SHIFT = 2;

    //////////////////////////////////////////////////
    // Data words.
    //////////////////////////////////////////////////

    typedef logic signed [7:0]  sample_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [15:0] prod_t;
    typedef logic signed [17:0] psum_t;
    typedef logic signed [15:0] result_t;

    // Saturation limits of result_t.
    localparam int RES_MAX = 32767;
    localparam int RES_MIN = -32768;

endpackage

`default_nettype wire

// File: src/conv_ram.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ram #(
    parameter type word_t = conv_pkg::sample_t,
    parameter int  DEPTH  = 64
) (
    input  wire logic                      clk,

    input  wire logic                      we,
    input  wire logic [conv_pkg::ADDR_W-1:0] waddr,
    input  word_t                          wdata,

    input  wire logic                      re,
    input  wire logic [conv_pkg::ADDR_W-1:0] raddr,
    output word_t                          rdata
);

    word_t mem [DEPTH];

    //////////////////////////////////////////////////
    // Write port.
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // Registered read port.
    //////////////////////////////////////////////////

    // Holds its last word while re is low.
    always_ff @(posedge clk)
    begin
        if (re)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: src/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,

    input  wire logic                        conv,
    input  wire logic [conv_pkg::ADDR_W-1:0] length,
    input  conv_pkg::weight_t                w0,
    input  conv_pkg::weight_t                w1,
    input  conv_pkg::weight_t                w2,
    input  conv_pkg::weight_t                bias,

    input  wire logic                        smp_we,
    input  wire logic [conv_pkg::ADDR_W-1:0] smp_waddr,
    input  conv_pkg::sample_t                smp_wdata,

    input  wire logic [conv_pkg::ADDR_W-1:0] res_raddr,
    output conv_pkg::result_t                res_rdata,

    output logic                             busy
);

    import conv_pkg::*;
    import conv_ctrl_pkg::*;

    logic              accept;
    logic              addr;
    logic              load;
    tap_sel_t          mux_sel;
    logic              acc_enable;
    logic              counter_enable;
    logic              store;
    logic              done;
    logic [ADDR_W-1:0] rd_addr0;
    logic [ADDR_W-1:0] rd_addr1;
    logic [ADDR_W-1:0] rd_addr2;
    logic [ADDR_W-1:0] wr_addr;

    // Start pulse, dropped while a run is active.
    assign accept = conv & ~busy;

    conv_control u_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .conv           (conv),
        .done           (done),
        .addr           (addr),
        .load           (load),
        .mux_sel        (mux_sel),
        .acc_enable     (acc_enable),
        .counter_enable (counter_enable),
        .store          (store),
        .busy           (busy)
    );

    conv_addr_gen u_addr_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .conv           (accept),
        .counter_enable (counter_enable),
        .length         (length),
        .rd_addr0       (rd_addr0),
        .rd_addr1       (rd_addr1),
        .rd_addr2       (rd_addr2),
        .wr_addr        (wr_addr),
        .done           (done)
    );

    conv_datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .smp_we     (smp_we),
        .smp_waddr  (smp_waddr),
        .smp_wdata  (smp_wdata),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .rd_addr2   (rd_addr2),
        .wr_addr    (wr_addr),
        .res_raddr  (res_raddr),
        .res_rdata  (res_rdata),
        .cfg_load   (accept),
        .w0         (w0),
        .w1         (w1),
        .w2         (w2),
        .bias       (bias),
        .addr       (addr),
        .load       (load),
        .mux_sel    (mux_sel),
        .acc_enable (acc_enable),
        .store      (store)
    );

endmodule

`default_nettype wire

// File: verification/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    import conv_pkg::*;

    localparam int NUM_CASES = 8;
    localparam int TIMEOUT   = 10 * MEM_DEPTH + 50;

    // Sample selector values are 0 random, 1 all max, 2 all min and 3 keep previous samples.
    typedef struct packed {
        int len;
        int w0;
        int w1;
        int w2;
        int bias;
        int sel;
        bit mid_conv;
    } case_t;

    logic              clk;
    logic              rst_n;
    logic              conv;
    logic [ADDR_W-1:0] length;
    weight_t           w0;
    weight_t           w1;
    weight_t           w2;
    weight_t           bias;
    logic              smp_we;
    logic [ADDR_W-1:0] smp_waddr;
    sample_t           smp_wdata;
    logic [ADDR_W-1:0] res_raddr;
    result_t           res_rdata;
    logic              busy;

    case_t cases     [NUM_CASES];
    int    smp_model [MEM_DEPTH];
    int    res_model [MEM_DEPTH];
    bit    res_valid [MEM_DEPTH];
    int    errors;
    int    checks;
    bit    timed_out;

    conv_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .conv      (conv),
        .length    (length),
        .w0        (w0),
        .w1        (w1),
        .w2        (w2),
        .bias      (bias),
        .smp_we    (smp_we),
        .smp_waddr (smp_waddr),
        .smp_wdata (smp_wdata),
        .res_raddr (res_raddr),
        .res_rdata (res_rdata),
        .busy      (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model and helpers.
    //////////////////////////////////////////////////

    // Weighted sum plus bias, arithmetic shift, 16-bit saturation.
    function automatic int expected_result(input int s0, input int s1, input int s2,
                                           input int k0, input int k1, input int k2,
                                           input int b);
        int acc;
        acc = s0 * k0 + s1 * k1 + s2 * k2 + b;
        acc = acc >>> OUT_SHIFT;
        if (acc > 32767)
        begin
            acc = 32767;
        end
        else if (acc < -32768)
        begin
            acc = -32768;
        end
        return acc;
    endfunction

    task automatic write_samples(input int sel, input int len);
        int v;
        if (sel != 3)
        begin
            for (int a = 0; a < len; a++)
            begin
                case (sel)
                    1: v = 127;
                    2: v = -128;
                    default: v = int'(sample_t'($urandom));
                endcase
                @(posedge clk);
                #1;
                smp_we    = 1'b1;
                smp_waddr = ADDR_W'(a);
                smp_wdata = sample_t'(v);
                smp_model[a] = v;
            end
            @(posedge clk);
            #1;
            smp_we = 1'b0;
        end
    endtask

    task automatic run_case(input case_t c);
        int n;
        int cycles;
        n = c.len - 2;
        for (int p = 0; p < n; p++)
        begin
            res_model[p] = expected_result(smp_model[p], smp_model[p + 1], smp_model[p + 2],
                                           c.w0, c.w1, c.w2, c.bias);
            res_valid[p] = 1'b1;
        end

        @(posedge clk);
        #1;
        conv   = 1'b1;
        length = ADDR_W'(c.len);
        w0     = weight_t'(c.w0);
        w1     = weight_t'(c.w1);
        w2     = weight_t'(c.w2);
        bias   = weight_t'(c.bias);
        @(posedge clk);
        #1;
        conv = 1'b0;
        checks++;
        assert (busy === 1'b1)
        else
        begin
            errors++;
            $display("ERROR: busy expected %h, got %h one cycle after conv", 1'b1, busy);
        end

        cycles = 0;
        while (busy === 1'b1 && cycles < TIMEOUT)
        begin
            cycles++;
            // A second start with a different setup is ignored.
            if (c.mid_conv && cycles == 15)
            begin
                conv   = 1'b1;
                length = ADDR_W'(5);
                w0     = ~weight_t'(c.w0);
                w2     = weight_t'(c.w1);
                bias   = weight_t'(-c.bias);
            end
            else if (c.mid_conv && cycles == 16)
            begin
                conv   = 1'b0;
                length = ADDR_W'(c.len);
                w0     = weight_t'(c.w0);
                w2     = weight_t'(c.w2);
                bias   = weight_t'(c.bias);
            end
            @(posedge clk);
            #1;
        end

        if (busy === 1'b1)
        begin
            timed_out = 1'b1;
            $display("Timed out waiting for busy to fall after %0d cycles", cycles);
        end
        else
        begin
            checks++;
            assert (cycles == 10 * n)
            else
            begin
                errors++;
                $display("ERROR: busy high cycles expected %h, got %h", 10 * n, cycles);
            end
        end
    endtask

    task automatic check_results();
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            @(posedge clk);
            #1;
            res_raddr = ADDR_W'(a);
            @(posedge clk);
            #1;
            if (res_valid[a])
            begin
                checks++;
                assert (res_rdata === result_t'(res_model[a]))
                else
                begin
                    errors++;
                    $display("ERROR: res_rdata[%0d] expected %h, got %h",
                             a, result_t'(res_model[a]), res_rdata);
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////

    initial
    begin
        rst_n     = 1'b0;
        conv      = 1'b0;
        length    = '0;
        w0        = '0;
        w1        = '0;
        w2        = '0;
        bias      = '0;
        smp_we    = 1'b0;
        smp_waddr = '0;
        smp_wdata = '0;
        res_raddr = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            res_valid[a] = 1'b0;
            smp_model[a] = 0;
            res_model[a] = 0;
        end
        void'($urandom(70548));

        // len, w0, w1, w2, bias, sel, mid_conv
        cases[0] = '{10, 3, -2, 5, 7, 0, 1'b0};
        cases[1] = '{20, -7, 4, 1, -20, 0, 1'b0};
        cases[2] = '{8, 127, 127, 127, 127, 1, 1'b0};
        cases[3] = '{8, 127, 127, 127, -128, 2, 1'b0};
        cases[4] = '{3, 1, 1, 1, 0, 0, 1'b0};
        cases[5] = '{64, -1, 2, -1, 3, 0, 1'b0};
        cases[6] = '{16, 5, -3, 2, 1, 0, 1'b1};
        cases[7] = '{6, -4, 6, -2, -9, 3, 1'b0};

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        checks++;
        assert (busy === 1'b0)
        else
        begin
            errors++;
            $display("ERROR: busy expected %h, got %h after reset", 1'b0, busy);
        end

        for (int i = 0; i < NUM_CASES && !timed_out; i++)
        begin
            write_samples(cases[i].sel, cases[i].len);
            run_case(cases[i]);
            if (!timed_out)
            begin
                check_results();
            end
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
